/* hdl/router_cfg_pkg.sv */
package router_cfg_pkg;

    // sources and lanes are numbered alike
    localparam int num_sources = 2;
    localparam int num_sinks = 2;

    // per-sink command queue
    localparam int cmd_depth = 8;

    // per-sink beat buffer, power of two
    localparam int buf_depth = 8;

    // fill level where a sink stops asking for a new burst
    localparam int buf_almost_full = 5;

    // width of one beat
    localparam int data_width = 32;

endpackage

/* hdl/router_beat_pkg.sv */
package router_beat_pkg;

    import router_cfg_pkg::*;

    // one beat's data word
    typedef logic [data_width-1:0] data_t;

    // source number, also the lane number
    typedef logic [$clog2(num_sources)-1:0] source_t;

    // sink number
    typedef logic [$clog2(num_sinks)-1:0] sink_t;

    // what a sink buffers per beat
    typedef struct packed {
        logic  last;
        data_t data;
    } beat_t;

endpackage

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int depth = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  payload_t               wr_data,
    output logic                   full,
    output logic                   almost_full,
    input  logic [$clog2(depth):0] almost_full_level,
    input  logic                   pop,
    output payload_t               rd_data,
    output logic                   empty
);

    // pointers wrap on their own, so depth must be a power of two
    payload_t mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word shows without a pop
    assign rd_data = mem[rd_ptr];

    assign empty = (count == '0);
    assign full = (count == ($clog2(depth) + 1)'(depth));
    assign almost_full = (count >= almost_full_level);

    // callers must look at the flags before they act
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

endmodule

/* hdl/channel_sink.sv */
`timescale 1ns/1ps

module channel_sink (
    input  logic                    clk,
    input  logic                    rst,

    output logic                    cmd_full,
    input  logic                    cmd_push,
    input  router_beat_pkg::source_t cmd_source,

    output logic                    want_valid,
    output router_beat_pkg::source_t want_lane,
    input  logic                    grant,
    input  router_beat_pkg::source_t grant_lane,

    input  logic                    lane_valid [router_cfg_pkg::num_sources],
    input  logic                    lane_last [router_cfg_pkg::num_sources],
    input  router_beat_pkg::data_t  lane_data [router_cfg_pkg::num_sources],
    output logic                    sink_take,

    input  logic                    sink_ready,
    output logic                    sink_valid,
    output logic                    sink_last,
    output router_beat_pkg::data_t  sink_data
);

    import router_cfg_pkg::*;
    import router_beat_pkg::*;

    source_t head_source;
    logic cmd_empty;

    logic granted;
    source_t lane;

    beat_t wr_beat;
    beat_t rd_beat;
    logic buf_full;
    logic buf_af;
    logic buf_empty;

    logic move;
    logic grant_clear;

    // commands leave the queue when the arbiter grants them
    sync_fifo #(
        .payload_t (source_t),
        .depth     (cmd_depth)
    ) u_cmd_fifo (
        .clk               (clk),
        .rst               (rst),
        .push              (cmd_push),
        .wr_data           (cmd_source),
        .full              (cmd_full),
        .almost_full       (),
        .almost_full_level (($clog2(cmd_depth) + 1)'(cmd_depth)),
        .pop               (grant),
        .rd_data           (head_source),
        .empty             (cmd_empty)
    );

    // granted lane, held until its last beat moves
    always_ff @(posedge clk) begin
        if (rst) begin
            granted <= 1'b0;
        end else if (grant) begin
            granted <= 1'b1;
        end else if (grant_clear) begin
            granted <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            lane <= grant_lane;
        end
    end

    assign sink_take = granted && !buf_full;
    assign move = sink_take && lane_valid[lane];
    assign grant_clear = move && lane_last[lane];

    assign wr_beat.last = lane_last[lane];
    assign wr_beat.data = lane_data[lane];

    sync_fifo #(
        .payload_t (beat_t),
        .depth     (buf_depth)
    ) u_beat_fifo (
        .clk               (clk),
        .rst               (rst),
        .push              (move),
        .wr_data           (wr_beat),
        .full              (buf_full),
        .almost_full       (buf_af),
        .almost_full_level (($clog2(buf_depth) + 1)'(buf_almost_full)),
        .pop               (sink_valid && sink_ready),
        .rd_data           (rd_beat),
        .empty             (buf_empty)
    );

    assign sink_valid = !buf_empty;
    assign sink_last = rd_beat.last;
    assign sink_data = rd_beat.data;

    // ask for the next burst while idle or on the final beat
    assign want_valid = !cmd_empty && !buf_af && (!granted || grant_clear);
    assign want_lane = head_source;

    // the arbiter must not hand over a lane mid-burst
    a_no_grant_overlap: assert property (
        @(posedge clk) disable iff (rst)
        grant |-> (!granted || grant_clear)
    );

endmodule

/* hdl/lane_arbiter.sv */
`timescale 1ns/1ps

module lane_arbiter (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     want_valid [router_cfg_pkg::num_sinks],
    input  router_beat_pkg::source_t want_lane [router_cfg_pkg::num_sinks],
    output logic                     grant [router_cfg_pkg::num_sinks],
    output router_beat_pkg::source_t grant_lane [router_cfg_pkg::num_sinks],
    input  logic                     sink_take [router_cfg_pkg::num_sinks],

    input  logic                     lane_valid [router_cfg_pkg::num_sources],
    input  logic                     lane_last [router_cfg_pkg::num_sources],
    output logic                     lane_ready [router_cfg_pkg::num_sources]
);

    import router_cfg_pkg::*;
    import router_beat_pkg::*;

    logic busy [num_sources];
    sink_t owner [num_sources];
    sink_t last_grant [num_sources];

    logic lane_end [num_sources];
    logic lane_free [num_sources];
    logic pick_valid [num_sources];
    sink_t pick [num_sources];

    logic sink_owns [num_sinks];

    // ready comes from whoever owns the lane
    always_comb begin
        for (int l = 0; l < num_sources; l++) begin
            lane_ready[l] = busy[l] && sink_take[owner[l]];
            lane_end[l] = lane_ready[l] && lane_valid[l] && lane_last[l];
            lane_free[l] = !busy[l] || lane_end[l];
        end
    end

    // rotating pick per lane, starting after the last winner
    always_comb begin
        sink_t cand;
        cand = '0;
        for (int s = 0; s < num_sinks; s++) begin
            grant[s] = 1'b0;
            grant_lane[s] = '0;
        end
        for (int l = 0; l < num_sources; l++) begin
            pick_valid[l] = 1'b0;
            pick[l] = '0;
            for (int k = 1; k <= num_sinks; k++) begin
                cand = sink_t'((int'(last_grant[l]) + k) % num_sinks);
                if (!pick_valid[l] && lane_free[l] && want_valid[cand] &&
                        want_lane[cand] == source_t'(l)) begin
                    pick_valid[l] = 1'b1;
                    pick[l] = cand;
                end
            end
            // a sink asks for one lane only, so no sink wins twice
            if (pick_valid[l]) begin
                grant[pick[l]] = 1'b1;
                grant_lane[pick[l]] = source_t'(l);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < num_sources; l++) begin
                busy[l] <= 1'b0;
                owner[l] <= '0;
                last_grant[l] <= '0;
            end
        end else begin
            for (int l = 0; l < num_sources; l++) begin
                if (pick_valid[l]) begin
                    busy[l] <= 1'b1;
                    owner[l] <= pick[l];
                    last_grant[l] <= pick[l];
                end else if (lane_end[l]) begin
                    busy[l] <= 1'b0;
                end
            end
        end
    end

    // which sinks hold a lane
    always_comb begin
        for (int s = 0; s < num_sinks; s++) begin
            sink_owns[s] = 1'b0;
            for (int l = 0; l < num_sources; l++) begin
                if (busy[l] && owner[l] == sink_t'(s)) begin
                    sink_owns[s] = 1'b1;
                end
            end
        end
    end

    // a sink taking beats while no lane is its own would skip lane_ready
    for (genvar s = 0; s < num_sinks; s++) begin : g_sink_chk
        a_take_owned: assert property (
            @(posedge clk) disable iff (rst)
            sink_take[s] |-> sink_owns[s]
        );
    end

    for (genvar a = 0; a < num_sources; a++) begin : g_lane_chk
        for (genvar b = a + 1; b < num_sources; b++) begin : g_pair_chk
            a_one_lane_per_sink: assert property (
                @(posedge clk) disable iff (rst)
                !(busy[a] && busy[b] && owner[a] == owner[b])
            );
        end
    end

endmodule

/* hdl/router_channel.sv */
`timescale 1ns/1ps

module router_channel (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     cmd_push [router_cfg_pkg::num_sinks],
    input  router_beat_pkg::source_t cmd_source [router_cfg_pkg::num_sinks],
    output logic                     cmd_full [router_cfg_pkg::num_sinks],

    input  logic                     lane_valid [router_cfg_pkg::num_sources],
    input  logic                     lane_last [router_cfg_pkg::num_sources],
    input  router_beat_pkg::data_t   lane_data [router_cfg_pkg::num_sources],
    output logic                     lane_ready [router_cfg_pkg::num_sources],

    input  logic                     sink_ready [router_cfg_pkg::num_sinks],
    output logic                     sink_valid [router_cfg_pkg::num_sinks],
    output logic                     sink_last [router_cfg_pkg::num_sinks],
    output router_beat_pkg::data_t   sink_data [router_cfg_pkg::num_sinks]
);

    import router_cfg_pkg::*;
    import router_beat_pkg::*;

    // sink to arbiter
    logic want_valid [num_sinks];
    source_t want_lane [num_sinks];
    logic sink_take [num_sinks];

    // arbiter to sink
    logic grant [num_sinks];
    source_t grant_lane [num_sinks];

    for (genvar s = 0; s < num_sinks; s++) begin : g_sink
        channel_sink u_sink (
            .clk        (clk),
            .rst        (rst),
            .cmd_full   (cmd_full[s]),
            .cmd_push   (cmd_push[s]),
            .cmd_source (cmd_source[s]),
            .want_valid (want_valid[s]),
            .want_lane  (want_lane[s]),
            .grant      (grant[s]),
            .grant_lane (grant_lane[s]),
            .lane_valid (lane_valid),
            .lane_last  (lane_last),
            .lane_data  (lane_data),
            .sink_take  (sink_take[s]),
            .sink_ready (sink_ready[s]),
            .sink_valid (sink_valid[s]),
            .sink_last  (sink_last[s]),
            .sink_data  (sink_data[s])
        );
    end

    // every sink sees all lanes, the arbiter decides who listens
    lane_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .want_valid (want_valid),
        .want_lane  (want_lane),
        .grant      (grant),
        .grant_lane (grant_lane),
        .sink_take  (sink_take),
        .lane_valid (lane_valid),
        .lane_last  (lane_last),
        .lane_ready (lane_ready)
    );

endmodule

/* test/router_channel_model.svh */
// bursts per source, and how the command lists are laid out
localparam int num_bursts = 16;
localparam int list_len = num_bursts;
localparam int lead_len = 6;
localparam int pool_len = 2 * (num_bursts - lead_len);

source_t cmd_list [num_sinks][list_len];

// 1 to 4 beats, spread over the sequence numbers
function automatic int burst_len(input int seq);
    return 1 + ((seq * 5 + 2) % 4);
endfunction

// source in [31:24], sequence number in [23:8], beat index in [7:0]
function automatic data_t beat_word(input source_t src, input int seq, input int idx);
    return {8'(src), 16'(seq), 8'(idx)};
endfunction

function automatic source_t expected_source(input int s, input int k);
    return cmd_list[s][k];
endfunction

// each sink starts on its own source, the rest is a shuffled pool
function automatic void build_cmd_lists();
    source_t pool [pool_len];
    source_t tmp;
    int j;
    for (int k = 0; k < lead_len; k++) begin
        cmd_list[0][k] = source_t'(0);
        cmd_list[1][k] = source_t'(1);
    end
    for (int i = 0; i < pool_len; i++) begin
        pool[i] = source_t'(i % 2);
    end
    for (int i = pool_len - 1; i > 0; i--) begin
        rng = xorshift(rng);
        j = int'(rng % (i + 1));
        tmp = pool[i];
        pool[i] = pool[j];
        pool[j] = tmp;
    end
    for (int k = 0; k < pool_len / 2; k++) begin
        cmd_list[0][lead_len + k] = pool[k];
        cmd_list[1][lead_len + k] = pool[pool_len / 2 + k];
    end
endfunction

/* test/router_channel_tb.sv */
`timescale 1ns/1ps

module router_channel_tb;

    import router_cfg_pkg::*;
    import router_beat_pkg::*;

    localparam int timeout_cycles = 20000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic cmd_push [num_sinks] = '{default: 1'b0};
    source_t cmd_source [num_sinks] = '{default: '0};
    logic cmd_full [num_sinks];
    logic lane_valid [num_sources] = '{default: 1'b0};
    logic lane_last [num_sources] = '{default: 1'b0};
    data_t lane_data [num_sources] = '{default: '0};
    logic lane_ready [num_sources];
    logic sink_ready [num_sinks] = '{default: 1'b0};
    logic sink_valid [num_sinks];
    logic sink_last [num_sinks];
    data_t sink_data [num_sinks];

    logic [31:0] rng = 32'h357c_951f;
    logic run = 1'b0;
    logic stall = 1'b0;
    int errors = 0;
    int done_bursts = 0;
    int stall_bursts = 0;
    int push_idx [num_sinks] = '{default: 0};
    int src_seq [num_sources] = '{default: 0};
    int src_idx [num_sources] = '{default: 0};
    int burst_idx [num_sinks] = '{default: 0};
    int beat_idx [num_sinks] = '{default: 0};
    int cur_seq [num_sinks] = '{default: 0};
    int last_seq [num_sinks][num_sources] = '{default: -1};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    `include "router_channel_model.svh"

    bit seen [num_sources][num_bursts];

    router_channel dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_push   (cmd_push),
        .cmd_source (cmd_source),
        .cmd_full   (cmd_full),
        .lane_valid (lane_valid),
        .lane_last  (lane_last),
        .lane_data  (lane_data),
        .lane_ready (lane_ready),
        .sink_ready (sink_ready),
        .sink_valid (sink_valid),
        .sink_last  (sink_last),
        .sink_data  (sink_data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_last(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_source(input string name, input source_t got, input source_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // a new burst on sink s, checked for range, duplicates and order
    task automatic note_burst(input int s, input source_t src, input int seq);
        if (seq >= num_bursts) begin
            errors++;
            $display("sink %0d got burst %0d of source %0d, past the last one", s, seq, src);
        end else begin
            if (seen[src][seq]) begin
                errors++;
                $display("burst %0d of source %0d was delivered twice", seq, src);
            end
            if (seq <= last_seq[s][src]) begin
                errors++;
                $display("sink %0d got burst %0d of source %0d out of order", s, seq, src);
            end
            seen[src][seq] = 1'b1;
            last_seq[s][src] = seq;
        end
    endtask

    // one idle cycle after each push, so cmd_full is current when read
    always @(posedge clk) begin
        for (int s = 0; s < num_sinks; s++) begin
            if (rst || !run || cmd_push[s]) begin
                cmd_push[s] <= 1'b0;
            end else if (push_idx[s] < list_len && !cmd_full[s]) begin
                cmd_push[s] <= 1'b1;
                cmd_source[s] <= cmd_list[s][push_idx[s]];
                push_idx[s]++;
            end
        end
    end

    // sources stream their bursts back to back
    always @(posedge clk) begin
        for (int l = 0; l < num_sources; l++) begin
            if (lane_valid[l] && lane_ready[l]) begin
                if (src_idx[l] == burst_len(src_seq[l]) - 1) begin
                    src_idx[l] = 0;
                    src_seq[l]++;
                end else begin
                    src_idx[l]++;
                end
            end
            if (!rst && run && src_seq[l] < num_bursts) begin
                lane_valid[l] <= 1'b1;
                lane_last[l] <= (src_idx[l] == burst_len(src_seq[l]) - 1);
                lane_data[l] <= beat_word(source_t'(l), src_seq[l], src_idx[l]);
            end else begin
                lane_valid[l] <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst || !run) begin
            sink_ready[0] <= 1'b0;
            sink_ready[1] <= 1'b0;
        end else if (stall) begin
            sink_ready[0] <= 1'b0;
            sink_ready[1] <= 1'b1;
        end else begin
            rng = xorshift(rng);
            sink_ready[0] <= rng[3];
            sink_ready[1] <= rng[17];
        end
    end

    // compare every accepted output beat with the model
    always @(posedge clk) begin
        source_t exp_src;
        int len;
        for (int s = 0; s < num_sinks; s++) begin
            if (!rst && sink_valid[s] && sink_ready[s]) begin
                if (burst_idx[s] >= list_len) begin
                    errors++;
                    $display("sink %0d delivered a beat after its last command", s);
                end else begin
                    exp_src = expected_source(s, burst_idx[s]);
                    if (beat_idx[s] == 0) begin
                        check_source($sformatf("sink_data[%0d] source", s),
                            source_t'(sink_data[s][24 +: $bits(source_t)]), exp_src);
                        cur_seq[s] = int'(sink_data[s][23:8]);
                        note_burst(s, exp_src, cur_seq[s]);
                    end
                    len = burst_len(cur_seq[s]);
                    check_data($sformatf("sink_data[%0d]", s), sink_data[s],
                        beat_word(exp_src, cur_seq[s], beat_idx[s]));
                    check_last($sformatf("sink_last[%0d]", s), sink_last[s],
                        beat_idx[s] == len - 1);
                    if (beat_idx[s] == len - 1) begin
                        beat_idx[s] = 0;
                        burst_idx[s]++;
                        done_bursts++;
                        if (stall && s == 1) begin
                            stall_bursts++;
                        end
                    end else begin
                        beat_idx[s]++;
                    end
                end
            end
        end
    end

    initial begin
        int wait_cycles;
        build_cmd_lists();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // idle after reset, nothing pushed yet
        repeat (5) begin
            @(negedge clk);
            for (int s = 0; s < num_sinks; s++) begin
                check_flag($sformatf("sink_valid[%0d]", s), sink_valid[s], 1'b0);
                check_flag($sformatf("cmd_full[%0d]", s), cmd_full[s], 1'b0);
            end
            for (int l = 0; l < num_sources; l++) begin
                check_flag($sformatf("lane_ready[%0d]", l), lane_ready[l], 1'b0);
            end
        end
        @(posedge clk);
        run <= 1'b1;
        stall <= 1'b1;
        repeat (40) @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        if (stall_bursts == 0) begin
            errors++;
            $display("sink 1 completed no burst while sink 0 was stalled");
        end
        wait_cycles = 0;
        while (done_bursts < 2 * num_bursts && wait_cycles < timeout_cycles) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (done_bursts < 2 * num_bursts) begin
            errors++;
            $display("timed out with %0d of %0d bursts delivered", done_bursts, 2 * num_bursts);
        end
        for (int l = 0; l < num_sources; l++) begin
            for (int q = 0; q < num_bursts; q++) begin
                if (!seen[l][q]) begin
                    errors++;
                    $display("burst %0d of source %0d never arrived", q, l);
                end
            end
        end
        $display("bursts delivered: %0d, errors: %0d", done_bursts, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+test
hdl/router_cfg_pkg.sv
hdl/router_beat_pkg.sv
hdl/sync_fifo.sv
hdl/channel_sink.sv
hdl/lane_arbiter.sv
hdl/router_channel.sv
test/router_channel_tb.sv
